// ==== rtl/iwc_pkg.sv ====
/*
 * Shared definitions for the read-path AXI ID width converter.
 * Holds the slave and master ID widths, the remap table limits,
 * the address and data widths, and the AR and R channel structs
 * for both ports.
 */

`default_nettype none

package iwc_pkg;

  // Port ID widths
  localparam int unsigned SlvIdWidth = 6;
  localparam int unsigned MstIdWidth = 2;

  // One remap entry per master ID
  localparam int unsigned TableSize    = 2 ** MstIdWidth;
  localparam int unsigned MaxTxnsPerId = 3;
  localparam int unsigned CntWidth     = 2;

  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 32;

  typedef logic [SlvIdWidth-1:0] slv_id_t;
  typedef logic [MstIdWidth-1:0] mst_id_t;

  // AR channel, single-beat reads only
  typedef struct packed {
    slv_id_t              id;
    logic [AddrWidth-1:0] addr;
  } slv_ar_t;

  typedef struct packed {
    mst_id_t              id;
    logic [AddrWidth-1:0] addr;
  } mst_ar_t;

  // R channel
  typedef struct packed {
    slv_id_t              id;
    logic [DataWidth-1:0] data;
    logic [1:0]           resp;
  } slv_r_t;

  typedef struct packed {
    mst_id_t              id;
    logic [DataWidth-1:0] data;
    logic [1:0]           resp;
  } mst_r_t;

endpackage

`default_nettype wire

// ==== rtl/iwc_spill_reg.sv ====
/*
 * Two-entry valid/ready register slice.
 * Main register feeds the output, a spill register catches the beat
 * that arrives while the output stalls. Full throughput, one cycle.
 */

`default_nettype none

module iwc_spill_reg #(
  parameter type payload_t = logic
) (
  input  wire      clk_i,
  input  wire      arst_n_i,
  input  payload_t data_i,
  input  logic     valid_i,
  output logic     ready_o,
  output payload_t data_o,
  output logic     valid_o,
  input  logic     ready_i
);

  payload_t a_data_q;
  payload_t b_data_q;
  logic     a_full_q;
  logic     b_full_q;
  logic     a_fill;
  logic     a_drain;
  logic     b_fill;
  logic     b_drain;

  // A takes new beats, B holds the beat that could not leave
  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) a_full_q <= a_fill;
      if (b_fill || b_drain) b_full_q <= b_fill;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) a_data_q <= data_i;
    if (b_fill) b_data_q <= a_data_q;
  end

  // Older beat sits in B whenever B is occupied
  assign valid_o = a_full_q || b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;
  assign ready_o = !a_full_q || !b_full_q;

endmodule

`default_nettype wire

// ==== rtl/iwc_id_remap.sv ====
/*
 * Read-path ID remapper.
 * Compresses slave AR IDs onto master IDs through a small table,
 * counts the reads outstanding per entry and restores the slave ID
 * on each returning R beat.
 */

`default_nettype none

module iwc_id_remap (
  input  wire              clk_i,
  input  wire              arst_n_i,
  // Slave side AR
  input  iwc_pkg::slv_ar_t slv_ar_i,
  input  logic             slv_ar_valid_i,
  output logic             slv_ar_ready_o,
  // Master side AR
  output iwc_pkg::mst_ar_t mst_ar_o,
  output logic             mst_ar_valid_o,
  input  logic             mst_ar_ready_i,
  // Master side R
  input  iwc_pkg::mst_r_t  mst_r_i,
  input  logic             mst_r_valid_i,
  output logic             mst_r_ready_o,
  // Slave side R
  output iwc_pkg::slv_r_t  slv_r_o,
  output logic             slv_r_valid_o,
  input  logic             slv_r_ready_i
);

  import iwc_pkg::*;

  typedef logic [CntWidth-1:0] cnt_t;

  // Result of a priority search over the table
  typedef struct packed {
    logic    found;
    mst_id_t idx;
  } search_t;

  // Lowest set bit wins
  function automatic search_t find_first(input logic [TableSize-1:0] vec);
    search_t res;
    res = '0;
    for (int i = TableSize - 1; i >= 0; i--) begin
      if (vec[i]) begin
        res.found = 1'b1;
        res.idx   = mst_id_t'(i);
      end
    end
    return res;
  endfunction

  // Table storage
  slv_id_t id_q  [TableSize];
  cnt_t    cnt_q [TableSize];
  cnt_t    cnt_d [TableSize];

  logic [TableSize-1:0] hit;
  logic [TableSize-1:0] free;
  search_t              hit_sel;
  search_t              free_sel;
  mst_id_t              ar_idx;
  logic                 ar_ok;
  logic                 ar_fire;
  logic                 r_fire;

  // Entry state per index
  always_comb begin
    for (int i = 0; i < TableSize; i++) begin
      free[i] = (cnt_q[i] == '0);
      hit[i]  = !free[i] && (id_q[i] == slv_ar_i.id);
    end
  end

  assign hit_sel  = find_first(hit);
  assign free_sel = find_first(free);

  // A live entry for this ID must be reused, otherwise take a free one
  always_comb begin
    ar_idx = '0;
    ar_ok  = 1'b0;
    if (hit_sel.found) begin
      ar_idx = hit_sel.idx;
      ar_ok  = (cnt_q[hit_sel.idx] < cnt_t'(MaxTxnsPerId));
    end else if (free_sel.found) begin
      ar_idx = free_sel.idx;
      ar_ok  = 1'b1;
    end
  end

  // AR stalls while the table has no room for this ID
  assign mst_ar_valid_o = slv_ar_valid_i && ar_ok;
  assign slv_ar_ready_o = mst_ar_ready_i && ar_ok;

  always_comb begin
    mst_ar_o      = '0;
    mst_ar_o.id   = ar_idx;
    mst_ar_o.addr = slv_ar_i.addr;
  end

  // R passes straight through with the stored slave ID
  assign slv_r_valid_o = mst_r_valid_i;
  assign mst_r_ready_o = slv_r_ready_i;

  always_comb begin
    slv_r_o      = '0;
    slv_r_o.id   = id_q[mst_r_i.id];
    slv_r_o.data = mst_r_i.data;
    slv_r_o.resp = mst_r_i.resp;
  end

  assign ar_fire = mst_ar_valid_o && mst_ar_ready_i;
  assign r_fire  = mst_r_valid_i && slv_r_ready_i;

  // Count update, an AR and an R on one entry cancel out
  always_comb begin
    logic inc;
    logic dec;
    for (int i = 0; i < TableSize; i++) begin
      inc = ar_fire && (ar_idx == mst_id_t'(i));
      dec = r_fire && (mst_r_i.id == mst_id_t'(i));
      cnt_d[i] = cnt_q[i];
      if (inc && !dec) begin
        cnt_d[i] = cnt_q[i] + cnt_t'(1);
      end else if (dec && !inc) begin
        cnt_d[i] = cnt_q[i] - cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < TableSize; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < TableSize; i++) begin
        cnt_q[i] <= cnt_d[i];
      end
    end
  end

  // Slave ID is only read while the entry's count is nonzero
  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      id_q[ar_idx] <= slv_ar_i.id;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/iwc_read_converter.sv ====
/*
 * Read-path AXI ID width converter, top level.
 * Register slices on both sides of the ID remapper, one pair per
 * direction, so each direction takes two cycles end to end.
 */

`default_nettype none

module iwc_read_converter (
  input  wire              clk_i,
  input  wire              arst_n_i,
  // Slave port
  input  iwc_pkg::slv_ar_t slv_ar_i,
  input  logic             slv_ar_valid_i,
  output logic             slv_ar_ready_o,
  output iwc_pkg::slv_r_t  slv_r_o,
  output logic             slv_r_valid_o,
  input  logic             slv_r_ready_i,
  // Master port
  output iwc_pkg::mst_ar_t mst_ar_o,
  output logic             mst_ar_valid_o,
  input  logic             mst_ar_ready_i,
  input  iwc_pkg::mst_r_t  mst_r_i,
  input  logic             mst_r_valid_i,
  output logic             mst_r_ready_o
);

  import iwc_pkg::*;

  // AR path
  slv_ar_t ar_slv;
  logic    ar_slv_valid;
  logic    ar_slv_ready;
  mst_ar_t ar_mst;
  logic    ar_mst_valid;
  logic    ar_mst_ready;

  // R path
  mst_r_t  r_mst;
  logic    r_mst_valid;
  logic    r_mst_ready;
  slv_r_t  r_slv;
  logic    r_slv_valid;
  logic    r_slv_ready;

  iwc_spill_reg #(
    .payload_t ( slv_ar_t )
  ) ar_in_q (
    .clk_i    ( clk_i          ),
    .arst_n_i ( arst_n_i       ),
    .data_i   ( slv_ar_i       ),
    .valid_i  ( slv_ar_valid_i ),
    .ready_o  ( slv_ar_ready_o ),
    .data_o   ( ar_slv         ),
    .valid_o  ( ar_slv_valid   ),
    .ready_i  ( ar_slv_ready   )
  );

  iwc_id_remap iwc_id_remap_i (
    .clk_i          ( clk_i        ),
    .arst_n_i       ( arst_n_i     ),
    .slv_ar_i       ( ar_slv       ),
    .slv_ar_valid_i ( ar_slv_valid ),
    .slv_ar_ready_o ( ar_slv_ready ),
    .mst_ar_o       ( ar_mst       ),
    .mst_ar_valid_o ( ar_mst_valid ),
    .mst_ar_ready_i ( ar_mst_ready ),
    .mst_r_i        ( r_mst        ),
    .mst_r_valid_i  ( r_mst_valid  ),
    .mst_r_ready_o  ( r_mst_ready  ),
    .slv_r_o        ( r_slv        ),
    .slv_r_valid_o  ( r_slv_valid  ),
    .slv_r_ready_i  ( r_slv_ready  )
  );

  iwc_spill_reg #(
    .payload_t ( mst_ar_t )
  ) ar_out_q (
    .clk_i    ( clk_i          ),
    .arst_n_i ( arst_n_i       ),
    .data_i   ( ar_mst         ),
    .valid_i  ( ar_mst_valid   ),
    .ready_o  ( ar_mst_ready   ),
    .data_o   ( mst_ar_o       ),
    .valid_o  ( mst_ar_valid_o ),
    .ready_i  ( mst_ar_ready_i )
  );

  iwc_spill_reg #(
    .payload_t ( mst_r_t )
  ) r_in_q (
    .clk_i    ( clk_i         ),
    .arst_n_i ( arst_n_i      ),
    .data_i   ( mst_r_i       ),
    .valid_i  ( mst_r_valid_i ),
    .ready_o  ( mst_r_ready_o ),
    .data_o   ( r_mst         ),
    .valid_o  ( r_mst_valid   ),
    .ready_i  ( r_mst_ready   )
  );

  iwc_spill_reg #(
    .payload_t ( slv_r_t )
  ) r_out_q (
    .clk_i    ( clk_i         ),
    .arst_n_i ( arst_n_i      ),
    .data_i   ( r_slv         ),
    .valid_i  ( r_slv_valid   ),
    .ready_o  ( r_slv_ready   ),
    .data_o   ( slv_r_o       ),
    .valid_o  ( slv_r_valid_o ),
    .ready_i  ( slv_r_ready_i )
  );

endmodule

`default_nettype wire

// ==== bench/tb_iwc_model.svh ====
/*
 * Testbench model for the read-path ID width converter.
 * LFSR random source, memory data rule and the bookkeeping of
 * reads outstanding at the slave and master ports.
 */

`ifndef TB_IWC_MODEL_SVH
`define TB_IWC_MODEL_SVH

// Fibonacci LFSR, taps 32 22 2 1
logic [31:0] lfsr_q = 32'hbf10afef;

function automatic logic [31:0] rnd(input int unsigned nbits);
  logic [31:0] res;
  logic        fb;
  res = '0;
  for (int unsigned i = 0; i < nbits; i++) begin
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    res    = {res[30:0], fb};
  end
  return res;
endfunction

// Memory contents: address followed by its inverse
function automatic logic [DataWidth-1:0] mem_data(input logic [AddrWidth-1:0] addr);
  return {addr, ~addr};
endfunction

// Reads accepted at the slave AR port, in issue order
slv_ar_t exp_q[$];
// Reads accepted at the master AR port and not yet answered
mst_ar_t pend_q[$];
// Outstanding reads per master ID and the slave ID they belong to
int      outst [TableSize];
slv_id_t owner [TableSize];
// Slave ID of each read, looked up by the low address bits
slv_id_t sid_of [512];

function automatic int find_exp(input slv_id_t id, input int from);
  for (int i = from; i < exp_q.size(); i++) begin
    if (exp_q[i].id == id) return i;
  end
  return -1;
endfunction

function automatic int find_pend(input mst_id_t id);
  for (int i = 0; i < pend_q.size(); i++) begin
    if (pend_q[i].id == id) return i;
  end
  return -1;
endfunction

`endif

// ==== bench/tb_iwc_read_converter.sv ====
/*
 * Testbench for the read-path AXI ID width converter.
 * Random master and memory agents, reference checks of data, ID,
 * per-ID order and mapping, table stall and back-pressure tests.
 */

`default_nettype none

module tb_iwc_read_converter;

  import iwc_pkg::*;

  `include "tb_iwc_model.svh"

  localparam int Timeout     = 4000;
  localparam int QuietCycles = 20;

  logic    clk_i;
  logic    arst_n_i;
  slv_ar_t slv_ar_i;
  logic    slv_ar_valid_i;
  logic    slv_ar_ready_o;
  slv_r_t  slv_r_o;
  logic    slv_r_valid_o;
  logic    slv_r_ready_i;
  mst_ar_t mst_ar_o;
  logic    mst_ar_valid_o;
  logic    mst_ar_ready_i;
  mst_r_t  mst_r_i;
  logic    mst_r_valid_i;
  logic    mst_r_ready_o;

  slv_ar_t issue_q[$];
  logic    bp_en;
  logic    timed_out;
  mst_id_t last_r_id;
  int      resp_budget;
  int      hold_cnt;
  int      seq;
  int      n_issued;
  int      n_ret;
  int      n_mst_ar;
  int      n_mst_r;
  int      errors;
  int      err_order;
  int      err_map;

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  iwc_read_converter iwc_read_converter_i (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .slv_ar_i       ( slv_ar_i       ),
    .slv_ar_valid_i ( slv_ar_valid_i ),
    .slv_ar_ready_o ( slv_ar_ready_o ),
    .slv_r_o        ( slv_r_o        ),
    .slv_r_valid_o  ( slv_r_valid_o  ),
    .slv_r_ready_i  ( slv_r_ready_i  ),
    .mst_ar_o       ( mst_ar_o       ),
    .mst_ar_valid_o ( mst_ar_valid_o ),
    .mst_ar_ready_i ( mst_ar_ready_i ),
    .mst_r_i        ( mst_r_i        ),
    .mst_r_valid_i  ( mst_r_valid_i  ),
    .mst_r_ready_o  ( mst_r_ready_o  )
  );

  task automatic timeout(input string what);
    $display("timeout: %s did not finish within %0d cycles", what, Timeout);
    timed_out = 1'b1;
    errors++;
  endtask

  task automatic report(input string name, input int n);
    if (n == 0) $display("%s: ok", name);
    else $display("%s: %0d errors", name, n);
  endtask

  // Small ID pool so that IDs repeat and share table entries
  function automatic slv_id_t pool_id();
    logic [31:0] r;
    r = rnd(3);
    return {r[2:0], 3'b101};
  endfunction

  task automatic queue_read(input slv_id_t id);
    slv_ar_t     ar;
    logic [31:0] r;
    r       = rnd(7);
    ar.id   = id;
    ar.addr = {r[6:0], seq[8:0]};
    sid_of[seq[8:0]] = id;
    issue_q.push_back(ar);
    seq++;
  endtask

  task automatic master_ar_seen(input mst_ar_t mar);
    slv_id_t sid;
    sid = sid_of[mar.addr[8:0]];
    assert (outst[mar.id] == 0 || owner[mar.id] == sid) else begin
      $display("mismatch at time %0t: slave ID on mst_ar_o.id %0d got %h expected %h",
               $time, mar.id, sid, owner[mar.id]);
      err_map++;
      errors++;
    end
    owner[mar.id] = sid;
    outst[mar.id]++;
    assert (outst[mar.id] <= int'(MaxTxnsPerId)) else begin
      $display("master ID %0d has %0d reads outstanding, above the limit",
               mar.id, outst[mar.id]);
      err_map++;
      errors++;
    end
    pend_q.push_back(mar);
    n_mst_ar++;
  endtask

  task automatic slave_r_seen(input slv_r_t sr);
    int f;
    int j;
    f = find_exp(sr.id, 0);
    assert (f >= 0) else begin
      $display("R beat at time %0t with slave ID %h matches no outstanding read", $time, sr.id);
      errors++;
    end
    if (f >= 0) begin
      // A later read of the same ID with this data means a reordering
      j = f;
      while (j >= 0 && mem_data(exp_q[j].addr) != sr.data) j = find_exp(sr.id, j + 1);
      assert (j == f) else begin
        if (j > f) begin
          $display("slave ID %h returned address %h ahead of an earlier read",
                   sr.id, exp_q[j].addr);
          err_order++;
        end else begin
          $display("mismatch at time %0t: slv_r_o.data got %h expected %h",
                   $time, sr.data, mem_data(exp_q[f].addr));
        end
        errors++;
      end
      exp_q.delete(j >= 0 ? j : f);
    end
    assert (sr.resp == 2'b00) else begin
      $display("mismatch at time %0t: slv_r_o.resp got %b expected 00", $time, sr.resp);
      errors++;
    end
    n_ret++;
  endtask

  task automatic drive(input logic mr_hs);
    int pick;
    int idx;
    slv_ar_valid_i = (issue_q.size() > 0);
    slv_ar_i       = (issue_q.size() > 0) ? issue_q[0] : '0;
    slv_r_ready_i  = bp_en ? (rnd(2) != 0) : 1'b1;
    mst_ar_ready_i = bp_en ? (rnd(2) != 0) : 1'b1;
    // Memory response stays on the bus until it is taken
    if (!mst_r_valid_i || mr_hs) begin
      mst_r_valid_i = 1'b0;
      if (hold_cnt > 0) begin
        hold_cnt--;
      end else if (pend_q.size() > 0 && resp_budget > 0) begin
        pick          = int'(rnd(8)) % pend_q.size();
        idx           = find_pend(pend_q[pick].id);
        mst_r_i.id    = pend_q[idx].id;
        mst_r_i.data  = mem_data(pend_q[idx].addr);
        mst_r_i.resp  = 2'b00;
        mst_r_valid_i = 1'b1;
        hold_cnt      = int'(rnd(2));
        resp_budget--;
      end
    end
  endtask

  // Sample at the falling edge, then update and drive after the rising edge
  task automatic cycle();
    logic    ar_hs;
    logic    mar_hs;
    logic    mr_hs;
    logic    sr_hs;
    mst_ar_t mar;
    slv_r_t  sr;
    @(negedge clk_i);
    ar_hs  = slv_ar_valid_i && slv_ar_ready_o;
    mar_hs = mst_ar_valid_o && mst_ar_ready_i;
    mr_hs  = mst_r_valid_i && mst_r_ready_o;
    sr_hs  = slv_r_valid_o && slv_r_ready_i;
    mar    = mst_ar_o;
    sr     = slv_r_o;
    @(posedge clk_i);
    #1;
    if (ar_hs) begin
      exp_q.push_back(issue_q.pop_front());
      n_issued++;
    end
    if (mar_hs) master_ar_seen(mar);
    if (mr_hs) begin
      pend_q.delete(find_pend(mst_r_i.id));
      outst[mst_r_i.id]--;
      last_r_id = mst_r_i.id;
      n_mst_r++;
    end
    if (sr_hs) slave_r_seen(sr);
    drive(mr_hs);
  endtask

  task automatic drain(input string what);
    int t;
    t = 0;
    while ((issue_q.size() > 0 || exp_q.size() > 0) && t < Timeout) begin
      cycle();
      t++;
    end
    if (t >= Timeout) timeout(what);
  endtask

  task automatic valids_low(input string phase);
    assert (!slv_r_valid_o) else begin
      $display("mismatch at time %0t: slv_r_valid_o got 1 expected 0 %s", $time, phase);
      errors++;
    end
    assert (!mst_ar_valid_o) else begin
      $display("mismatch at time %0t: mst_ar_valid_o got 1 expected 0 %s", $time, phase);
      errors++;
    end
  endtask

  task automatic reset_test();
    for (int i = 0; i < 4; i++) begin
      @(negedge clk_i);
      valids_low("during reset");
      @(posedge clk_i);
      #1;
    end
    arst_n_i = 1'b1;
    for (int i = 0; i < 2; i++) begin
      @(negedge clk_i);
      valids_low("after reset");
      assert (slv_ar_ready_o && mst_r_ready_o) else begin
        $display("ready outputs are not both high after reset");
        errors++;
      end
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic random_traffic(input int n, input string what);
    int t;
    for (int i = 0; i < n; i++) begin
      queue_read(pool_id());
      t = 0;
      while (issue_q.size() > 2 && t < Timeout) begin
        cycle();
        t++;
      end
      if (t >= Timeout) timeout(what);
    end
    drain(what);
    // Every read crosses the master port exactly once in each direction
    assert (n_ret == n_issued && n_mst_ar == n_issued && n_mst_r == n_issued) else begin
      $display("mismatch at time %0t: read counts got %0d slv_r_o %0d mst_ar_o %0d mst_r_i",
               $time, n_ret, n_mst_ar, n_mst_r);
      $display("mismatch at time %0t: read counts expected %0d each", $time, n_issued);
      errors++;
    end
  endtask

  // Fill the table or one entry, then check the extra read waits for a response
  task automatic stall_test(input logic same_id);
    slv_id_t     base;
    logic [31:0] r;
    int          n;
    int          mar0;
    int          mr0;
    int          t;
    n    = same_id ? int'(MaxTxnsPerId) + 1 : int'(TableSize) + 1;
    r    = rnd(6);
    base = r[5:0];
    mar0 = n_mst_ar;
    mr0  = n_mst_r;
    resp_budget = 0;
    for (int i = 0; i < n; i++) queue_read(same_id ? base : base + slv_id_t'(i));
    t = 0;
    while (n_mst_ar - mar0 < n - 1 && t < Timeout) begin
      cycle();
      t++;
    end
    if (t >= Timeout) timeout("table fill");
    repeat (QuietCycles) cycle();
    assert (n_mst_ar - mar0 == n - 1) else begin
      $display("%0d reads passed the master AR port with no room left, %0d allowed",
               n_mst_ar - mar0, n - 1);
      errors++;
    end
    resp_budget = 1;
    t = 0;
    while (n_mst_ar - mar0 < n && t < Timeout) begin
      cycle();
      t++;
    end
    if (t >= Timeout) timeout("stalled read");
    if (n_mst_ar - mar0 == n) begin
      assert (n_mst_r - mr0 == 1) else begin
        $display("stalled read left before a response completed");
        errors++;
      end
      assert (pend_q[pend_q.size() - 1].id == last_r_id) else begin
        $display("mismatch at time %0t: mst_ar_o.id got %0d expected %0d",
                 $time, pend_q[pend_q.size() - 1].id, last_r_id);
        errors++;
      end
    end
    resp_budget = 1 << 30;
    drain("stalled reads");
  endtask

  initial begin
    int e0;
    int o0;
    int m0;
    arst_n_i       = 1'b0;
    slv_ar_i       = '0;
    slv_ar_valid_i = 1'b0;
    slv_r_ready_i  = 1'b1;
    mst_ar_ready_i = 1'b1;
    mst_r_i        = '0;
    mst_r_valid_i  = 1'b0;
    bp_en          = 1'b0;
    timed_out      = 1'b0;
    last_r_id      = '0;
    resp_budget    = 1 << 30;
    hold_cnt       = 0;
    seq            = 0;
    n_issued       = 0;
    n_ret          = 0;
    n_mst_ar       = 0;
    n_mst_r        = 0;
    errors         = 0;
    err_order      = 0;
    err_map        = 0;
    for (int i = 0; i < int'(TableSize); i++) outst[i] = 0;

    reset_test();
    report("reset state", errors);

    e0 = errors;
    o0 = err_order;
    m0 = err_map;
    random_traffic(300, "random reads");
    report("data and ID return", errors - e0 - (err_order - o0) - (err_map - m0));
    report("per-ID order", err_order - o0);
    report("mapping consistency", err_map - m0);

    if (!timed_out) begin
      e0 = errors;
      stall_test(1'b0);
      if (!timed_out) stall_test(1'b1);
      report("table exhaustion stall", errors - e0);
    end

    if (!timed_out) begin
      e0    = errors;
      bp_en = 1'b1;
      random_traffic(200, "back-pressure reads");
      bp_en = 1'b0;
      report("back-pressure", errors - e0);
    end

    $display("reads issued %0d, returned %0d, errors %0d", n_issued, n_ret, errors);
    if (errors == 0 && !timed_out) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+bench
rtl/iwc_pkg.sv
rtl/iwc_spill_reg.sv
rtl/iwc_id_remap.sv
rtl/iwc_read_converter.sv
bench/tb_iwc_read_converter.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_iwc_read_converter
FILELIST  := compile.f
FLAGS     := --timing --assert
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
